// ==== src/ucie_pkg.sv ====
`default_nettype none

package ucie_pkg;

    // ======================================
    // Link geometry
    // ======================================

    // Upper bound on protocol streams
    localparam int MAX_PROTOCOLS = 4;
    localparam int PROTO_ID_W    = 2;
    localparam int PAYLOAD_W     = 32;
    localparam int SEQ_W         = 8;
    localparam int CRC_W         = 8;

    // Alternating ones and zeros for training flits
    localparam logic [PAYLOAD_W-1:0] TRAIN_PATTERN = 32'hAAAA_AAAA;

    // ======================================
    // Flit formats
    // ======================================

    // Offered by one source, ID implied by port index
    typedef struct packed {
        logic                 valid;
        logic [PAYLOAD_W-1:0] payload;
    } proto_flit_t;

    // Winner of arbitration
    typedef struct packed {
        logic                  valid;
        logic [PROTO_ID_W-1:0] proto_id;
        logic [PAYLOAD_W-1:0]  payload;
    } granted_flit_t;

    typedef enum logic [1:0] {
        FLIT_TRAIN = 2'd0,
        FLIT_DATA  = 2'd1
    } flit_kind_e;

    // As seen on the die-to-die link
    typedef struct packed {
        logic                  valid;
        flit_kind_e            kind;
        logic [SEQ_W-1:0]      seq;
        logic [PROTO_ID_W-1:0] proto_id;
        logic [PAYLOAD_W-1:0]  payload;
        logic [CRC_W-1:0]      crc;
    } link_flit_t;

    typedef enum logic [1:0] {
        LINK_DOWN   = 2'd0,
        LINK_TRAIN  = 2'd1,
        LINK_ACTIVE = 2'd2
    } link_state_e;

    // ======================================
    // CRC-8, poly 0x07, init 0
    // ======================================

    // Covers protocol ID then payload, MSB first; sequence number not covered
    function automatic logic [CRC_W-1:0] crc8_calc(
        input logic [PROTO_ID_W-1:0] proto_id,
        input logic [PAYLOAD_W-1:0]  payload
    );
        logic [PROTO_ID_W+PAYLOAD_W-1:0] data;
        logic [CRC_W-1:0]                crc;
        logic                            feedback;
        data = {proto_id, payload};
        crc  = '0;
        for (int i = PROTO_ID_W + PAYLOAD_W - 1; i >= 0; i--) begin
            feedback = crc[CRC_W-1] ^ data[i];
            crc      = {crc[CRC_W-2:0], 1'b0};
            if (feedback) begin
                crc = crc ^ 8'h07;
            end
        end
        return crc;
    endfunction

endpackage

`default_nettype wire

// ==== src/proto_ingress_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module proto_ingress_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           async_rst_n,
    input  ucie_pkg::proto_flit_t          push_flit,
    input  logic                           pop,
    output logic [ucie_pkg::PAYLOAD_W-1:0] head_payload,
    output logic                           nonempty,
    output logic                           credit_return
);

    import ucie_pkg::*;

    // Depth is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // ======================================
    // Storage and pointers
    // ======================================

    logic [PAYLOAD_W-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 push_en;
    logic                 pop_en;
    logic                 full;

    assign push_en  = push_flit.valid;
    // Pop on an empty queue is ignored
    assign pop_en   = pop & nonempty;
    assign nonempty = (count != '0);
    assign full     = (count == CNT_W'(QUEUE_DEPTH));

    // Head visible the cycle after the write edge
    assign head_payload = mem[rd_ptr];

    // Payload array
    always_ff @(posedge clk) begin
        if (push_en) begin
            mem[wr_ptr] <= push_flit.payload;
        end
    end

    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Occupancy, simultaneous push and pop holds
            case ({push_en, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ======================================
    // Credit return to the source
    // ======================================

    // One pulse per released entry, one cycle after the pop
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop_en;
        end
    end

    // Source pushed without holding a credit
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!async_rst_n)
        push_flit.valid |-> !full
    ) else $error("proto_ingress_queue: push into full queue, source credit violation");

endmodule

`default_nettype wire

// ==== src/proto_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module proto_arbiter #(
    parameter int NUM_PROTOCOLS = 4
) (
    input  logic                           clk,
    input  logic                           async_rst_n,
    input  logic [NUM_PROTOCOLS-1:0]       nonempty,
    input  logic [ucie_pkg::PAYLOAD_W-1:0] head_payload [NUM_PROTOCOLS],
    input  logic                           framer_ready,
    output logic [NUM_PROTOCOLS-1:0]       pop,
    output ucie_pkg::granted_flit_t        granted
);

    import ucie_pkg::*;

    // Elaboration check on stream count
    if (NUM_PROTOCOLS < 2 || NUM_PROTOCOLS > MAX_PROTOCOLS) begin : gen_bad_count
        $error("proto_arbiter: NUM_PROTOCOLS out of range");
    end

    logic [PROTO_ID_W-1:0] ptr;
    logic [PROTO_ID_W-1:0] grant_id;
    logic                  found;

    // ======================================
    // Round-robin search
    // ======================================

    // First non-empty queue at or after the pointer
    always_comb begin : grant_search
        int idx;
        found    = 1'b0;
        grant_id = '0;
        for (int off = 0; off < NUM_PROTOCOLS; off++) begin
            idx = (int'(ptr) + off) % NUM_PROTOCOLS;
            if (!found && nonempty[idx]) begin
                found    = 1'b1;
                grant_id = PROTO_ID_W'(idx);
            end
        end
    end

    always_comb begin
        granted.valid    = found;
        granted.proto_id = grant_id;
        granted.payload  = head_payload[grant_id];
        // Pop only on a real handoff to the framer
        pop = '0;
        if (found && framer_ready) begin
            pop[grant_id] = 1'b1;
        end
    end

    // Pointer moves past the winner, wraps at NUM_PROTOCOLS
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            ptr <= '0;
        end else if (found && framer_ready) begin
            if (grant_id == PROTO_ID_W'(NUM_PROTOCOLS - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= grant_id + 1'b1;
            end
        end
    end

    // At most one queue drained per cycle, never an empty one
    a_pop_onehot: assert property (
        @(posedge clk) disable iff (!async_rst_n)
        $onehot0(pop) && ((pop & ~nonempty) == '0)
    ) else $error("proto_arbiter: bad pop vector");

endmodule

`default_nettype wire

// ==== src/flit_framer.sv ====
`timescale 1ns/10ps
`default_nettype none

module flit_framer (
    input  logic                    clk,
    input  logic                    async_rst_n,
    input  ucie_pkg::granted_flit_t granted,
    output logic                    framer_ready,
    input  logic                    port_ready,
    output ucie_pkg::link_flit_t    framed
);

    import ucie_pkg::*;

    // Stage 1, registered flit plus sequence stamp
    logic                  s1_valid;
    logic [PROTO_ID_W-1:0] s1_proto_id;
    logic [PAYLOAD_W-1:0]  s1_payload;
    logic [SEQ_W-1:0]      s1_seq;
    // Stage 2, CRC attached
    logic                  s2_valid;
    logic [PROTO_ID_W-1:0] s2_proto_id;
    logic [PAYLOAD_W-1:0]  s2_payload;
    logic [SEQ_W-1:0]      s2_seq;
    logic [CRC_W-1:0]      s2_crc;

    logic [SEQ_W-1:0]      seq_cnt;
    logic                  s2_advance;
    logic                  accept;

    // ======================================
    // Pipeline control
    // ======================================

    // Stage 2 frees up when empty or drained by the port
    assign s2_advance   = !s2_valid || port_ready;
    assign framer_ready = !s1_valid || s2_advance;
    assign accept       = granted.valid && framer_ready;

    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            seq_cnt  <= '0;
        end else begin
            if (framer_ready) begin
                s1_valid <= granted.valid;
            end
            if (s2_advance) begin
                s2_valid <= s1_valid;
            end
            // Wraps at 2^SEQ_W
            if (accept) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_proto_id <= granted.proto_id;
            s1_payload  <= granted.payload;
            s1_seq      <= seq_cnt;
        end
        if (s2_advance) begin
            s2_proto_id <= s1_proto_id;
            s2_payload  <= s1_payload;
            s2_seq      <= s1_seq;
            s2_crc      <= crc8_calc(s1_proto_id, s1_payload);
        end
    end

    // ======================================
    // Output assembly
    // ======================================

    always_comb begin
        framed.valid    = s2_valid;
        framed.kind     = FLIT_DATA;
        framed.seq      = s2_seq;
        framed.proto_id = s2_proto_id;
        framed.payload  = s2_payload;
        framed.crc      = s2_crc;
    end

    // Held flit must not change under back-pressure
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!async_rst_n)
        framed.valid && !port_ready |=> $stable(framed)
    ) else $error("flit_framer: framed flit changed while stalled");

endmodule

`default_nettype wire

// ==== src/link_tx_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module link_tx_port #(
    parameter int LINK_CREDITS = 8
) (
    input  logic                 clk,
    input  logic                 async_rst_n,
    input  logic                 link_enable,
    input  logic                 remote_train_ack,
    input  logic                 link_credit_return,
    input  ucie_pkg::link_flit_t framed,
    output logic                 port_ready,
    output ucie_pkg::link_flit_t link_out,
    output logic                 link_up
);

    import ucie_pkg::*;

    localparam int CRD_W = $clog2(LINK_CREDITS + 1);

    // Fixed training flit, protocol 0 and sequence 0
    localparam logic [CRC_W-1:0] TRAIN_CRC = crc8_calc('0, TRAIN_PATTERN);
    localparam link_flit_t TRAIN_FLIT = '{
        valid:    1'b1,
        kind:     FLIT_TRAIN,
        seq:      '0,
        proto_id: '0,
        payload:  TRAIN_PATTERN,
        crc:      TRAIN_CRC
    };

    link_state_e      state;
    link_state_e      state_next;
    logic [CRD_W-1:0] credit_cnt;
    logic             data_sent;

    // ======================================
    // Training FSM
    // ======================================

    always_comb begin
        state_next = state;
        case (state)
            LINK_DOWN:   if (link_enable) state_next = LINK_TRAIN;
            LINK_TRAIN:  if (remote_train_ack) state_next = LINK_ACTIVE;
            LINK_ACTIVE: state_next = LINK_ACTIVE;
            default:     state_next = LINK_DOWN;
        endcase
        // Losing enable always drops the link
        if (!link_enable) begin
            state_next = LINK_DOWN;
        end
    end

    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            state <= LINK_DOWN;
        end else begin
            state <= state_next;
        end
    end

    assign link_up    = (state == LINK_ACTIVE);
    assign port_ready = link_up && (credit_cnt != '0);
    assign data_sent  = framed.valid && port_ready;

    // ======================================
    // Remote credit counter
    // ======================================

    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            credit_cnt <= '0;
        end else if (state_next == LINK_ACTIVE && state != LINK_ACTIVE) begin
            // Fresh pool on link-up
            credit_cnt <= CRD_W'(LINK_CREDITS);
        end else if (link_up) begin
            case ({link_credit_return, data_sent})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ======================================
    // Registered link output
    // ======================================

    // Training flits stop on the ack edge, so none trail link-up
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            link_out <= '0;
        end else if (state_next == LINK_TRAIN) begin
            link_out <= TRAIN_FLIT;
        end else if (data_sent) begin
            link_out <= framed;
        end else begin
            link_out.valid <= 1'b0;
        end
    end

    // Remote side returned more buffers than it was given
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!async_rst_n)
        credit_cnt <= CRD_W'(LINK_CREDITS)
    ) else $error("link_tx_port: link credit count above LINK_CREDITS");

endmodule

`default_nettype wire

// ==== src/d2d_link_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module d2d_link_controller #(
    parameter int NUM_PROTOCOLS = 4,
    parameter int QUEUE_DEPTH   = 4,
    parameter int LINK_CREDITS  = 8
) (
    input  logic                   clk,
    input  logic                   async_rst_n,
    // Protocol side
    input  ucie_pkg::proto_flit_t  proto_in [NUM_PROTOCOLS],
    output logic [NUM_PROTOCOLS-1:0] proto_credit_return,
    // Link side
    input  logic                   link_enable,
    input  logic                   remote_train_ack,
    input  logic                   link_credit_return,
    output ucie_pkg::link_flit_t   link_out,
    output logic                   link_up
);

    import ucie_pkg::*;

    // ======================================
    // Internal nets
    // ======================================

    logic [PAYLOAD_W-1:0]     head_payload [NUM_PROTOCOLS];
    logic [NUM_PROTOCOLS-1:0] nonempty;
    logic [NUM_PROTOCOLS-1:0] pop;
    granted_flit_t            granted;
    logic                     framer_ready;
    link_flit_t               framed;
    logic                     port_ready;

    // One ingress FIFO per protocol stream
    for (genvar p = 0; p < NUM_PROTOCOLS; p++) begin : gen_queue
        proto_ingress_queue #(
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) proto_ingress_queue_i (
            .clk           (clk),
            .async_rst_n   (async_rst_n),
            .push_flit     (proto_in[p]),
            .pop           (pop[p]),
            .head_payload  (head_payload[p]),
            .nonempty      (nonempty[p]),
            .credit_return (proto_credit_return[p])
        );
    end

    // Interleave streams
    proto_arbiter #(
        .NUM_PROTOCOLS (NUM_PROTOCOLS)
    ) proto_arbiter_i (
        .clk          (clk),
        .async_rst_n  (async_rst_n),
        .nonempty     (nonempty),
        .head_payload (head_payload),
        .framer_ready (framer_ready),
        .pop          (pop),
        .granted      (granted)
    );

    // Sequence and CRC
    flit_framer flit_framer_i (
        .clk          (clk),
        .async_rst_n  (async_rst_n),
        .granted      (granted),
        .framer_ready (framer_ready),
        .port_ready   (port_ready),
        .framed       (framed)
    );

    // Training and link credits
    link_tx_port #(
        .LINK_CREDITS (LINK_CREDITS)
    ) link_tx_port_i (
        .clk                (clk),
        .async_rst_n        (async_rst_n),
        .link_enable        (link_enable),
        .remote_train_ack   (remote_train_ack),
        .link_credit_return (link_credit_return),
        .framed             (framed),
        .port_ready         (port_ready),
        .link_out           (link_out),
        .link_up            (link_up)
    );

endmodule

`default_nettype wire

// ==== tests/d2d_link_controller_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module d2d_link_controller_tb;

    import ucie_pkg::*;

    localparam int NUM_PROTOCOLS = 4;
    localparam int QUEUE_DEPTH   = 4;
    localparam int LINK_CREDITS  = 8;
    localparam int MAX_ENTRIES   = 32;
    localparam int TIMEOUT       = 300;
    // CRC-8 of protocol 0 with the alternating training word
    localparam logic [CRC_W-1:0] TRAIN_CRC = 8'h69;

    logic                     clk;
    logic                     async_rst_n;
    proto_flit_t              proto_in [NUM_PROTOCOLS];
    logic [NUM_PROTOCOLS-1:0] proto_credit_return;
    logic                     link_enable;
    logic                     remote_train_ack;
    logic                     link_credit_return;
    link_flit_t               link_out;
    logic                     link_up;

    // Entries from the stimulus file
    int                    n_entries;
    logic [PROTO_ID_W-1:0] file_pid [MAX_ENTRIES];
    logic [PAYLOAD_W-1:0]  file_payload [MAX_ENTRIES];
    logic [CRC_W-1:0]      file_crc [MAX_ENTRIES];

    // Pending file indices per protocol, circular
    int exp_idx [NUM_PROTOCOLS][64];
    int exp_head [NUM_PROTOCOLS];
    int exp_tail [NUM_PROTOCOLS];

    // Source and remote model bookkeeping
    int               pushed [NUM_PROTOCOLS];
    int               credit_pulses [NUM_PROTOCOLS];
    int               link_count [NUM_PROTOCOLS];
    int               max_outstanding;
    int               data_count;
    int               train_count;
    int               owed;
    int               release_budget;
    bit               returns_on;
    bit               rr_check;
    int               rr_next;
    logic [SEQ_W-1:0] next_seq;
    int               checks;
    int               errors;
    integer           seed;

    d2d_link_controller #(
        .NUM_PROTOCOLS (NUM_PROTOCOLS),
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .LINK_CREDITS  (LINK_CREDITS)
    ) d2d_link_controller_i (
        .clk                 (clk),
        .async_rst_n         (async_rst_n),
        .proto_in            (proto_in),
        .proto_credit_return (proto_credit_return),
        .link_enable         (link_enable),
        .remote_train_ack    (remote_train_ack),
        .link_credit_return  (link_credit_return),
        .link_out            (link_out),
        .link_up             (link_up)
    );

    always #2 clk = ~clk;

    // ======================================
    // Compare tasks
    // ======================================

    task automatic compare_link_flit(input link_flit_t actual, input link_flit_t expected,
                                     input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0.1f ns %s: got %h expected %h", $realtime, what, actual, expected);
        end
    endtask

    task automatic compare_state(input logic up_act, input logic up_exp,
                                 input flit_kind_e kind_act, input flit_kind_e kind_exp,
                                 input string what);
        checks++;
        if (up_act !== up_exp || kind_act !== kind_exp) begin
            errors++;
            $display("[FAIL] %0.1f ns %s: link_up %b kind %0d, expected link_up %b kind %0d",
                     $realtime, what, up_act, kind_act, up_exp, kind_exp);
        end
    endtask

    task automatic compare_count(input int actual, input int expected, input string what);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %0.1f ns %s: got %0d expected %0d", $realtime, what, actual, expected);
        end
    endtask

    // ======================================
    // Helpers
    // ======================================

    task automatic abort_run(input string reason);
        $display("Run stopped at %0.1f ns: %s", $realtime, reason);
        $display("Test failures found");
        $finish;
    endtask

    // One cycle, landing at the drive point
    task automatic step();
        @(posedge clk);
        #0.5;
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            step();
        end
    endtask

    task automatic wait_data(input int target, input string what);
        for (int t = 0; t < TIMEOUT && data_count < target; t++) begin
            step();
        end
        if (data_count < target) begin
            abort_run({"timeout waiting for ", what});
        end
    endtask

    task automatic wait_link(input logic up);
        for (int t = 0; t < TIMEOUT && link_up !== up; t++) begin
            step();
        end
        if (link_up !== up) begin
            abort_run("timeout waiting for link_up to change");
        end
    endtask

    task automatic wait_train_flits(input int n);
        for (int t = 0; t < TIMEOUT && train_count < n; t++) begin
            step();
        end
        if (train_count < n) begin
            abort_run("timeout waiting for training flits");
        end
    endtask

    function automatic bit all_settled();
        bit done;
        done = (owed == 0);
        for (int p = 0; p < NUM_PROTOCOLS; p++) begin
            if (pushed[p] != credit_pulses[p]) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    // All credits back on both sides
    task automatic settle_credits();
        for (int t = 0; t < TIMEOUT && !all_settled(); t++) begin
            step();
        end
        if (!all_settled()) begin
            abort_run("timeout waiting for credits to return");
        end
        wait_cycles(2);
    endtask

    task automatic load_file();
        int                   fd;
        int                   pid;
        logic [PAYLOAD_W-1:0] pl;
        logic [CRC_W-1:0]     crc;
        logic [8*128-1:0]     line;
        n_entries = 0;
        fd = $fopen("tests/link_input.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/link_input.txt");
        end else begin
            while (!$feof(fd) && n_entries < MAX_ENTRIES) begin
                line = '0;
                // Comment and blank lines yield no three fields
                if ($fgets(line, fd) != 0 && $sscanf(line, "%d %h %h", pid, pl, crc) == 3) begin
                    file_pid[n_entries]     = PROTO_ID_W'(pid);
                    file_payload[n_entries] = pl;
                    file_crc[n_entries]     = crc;
                    n_entries++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Protocol source, respects its queue credits
    task automatic push_entry(input int idx);
        int p;
        int t;
        p = file_pid[idx];
        t = 0;
        while (pushed[p] - credit_pulses[p] >= QUEUE_DEPTH) begin
            step();
            t++;
            if (t > TIMEOUT) begin
                abort_run("timeout waiting for a protocol credit");
            end
        end
        exp_idx[p][exp_tail[p] % 64] = idx;
        exp_tail[p]++;
        pushed[p]++;
        if (pushed[p] - credit_pulses[p] > max_outstanding) begin
            max_outstanding = pushed[p] - credit_pulses[p];
        end
        proto_in[p].valid   = 1'b1;
        proto_in[p].payload = file_payload[idx];
        step();
        proto_in[p].valid = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int base_err);
        if (errors == base_err) begin
            $display("Test %0d (%s): ok", num, name);
        end else begin
            $display("Test %0d (%s): %0d errors", num, name, errors - base_err);
        end
    endtask

    // ======================================
    // Link monitor and remote model
    // ======================================

    task automatic check_data_flit();
        link_flit_t expected;
        int         p;
        int         idx;
        p = rr_check ? rr_next : int'(link_out.proto_id);
        data_count++;
        owed++;
        link_count[link_out.proto_id]++;
        if (exp_head[p] == exp_tail[p]) begin
            errors++;
            $display("DATA flit for protocol %0d arrived with nothing pending at %0.1f ns",
                     p, $realtime);
        end else begin
            idx = exp_idx[p][exp_head[p] % 64];
            exp_head[p]++;
            expected.valid    = 1'b1;
            expected.kind     = FLIT_DATA;
            expected.seq      = next_seq;
            expected.proto_id = PROTO_ID_W'(p);
            expected.payload  = file_payload[idx];
            expected.crc      = file_crc[idx];
            compare_link_flit(link_out, expected, "data flit");
        end
        next_seq++;
        rr_next = (p + 1) % NUM_PROTOCOLS;
    endtask

    task automatic check_train_flit();
        link_flit_t expected;
        train_count++;
        expected.valid    = 1'b1;
        expected.kind     = FLIT_TRAIN;
        expected.seq      = '0;
        expected.proto_id = '0;
        expected.payload  = TRAIN_PATTERN;
        expected.crc      = TRAIN_CRC;
        compare_link_flit(link_out, expected, "training flit");
        compare_state(link_up, 1'b0, link_out.kind, FLIT_TRAIN, "training flit vs link_up");
    endtask

    // Sample mid-cycle, away from the edges
    always @(negedge clk) begin
        if (async_rst_n) begin
            for (int p = 0; p < NUM_PROTOCOLS; p++) begin
                if (proto_credit_return[p]) begin
                    credit_pulses[p]++;
                end
            end
            if (link_out.valid && link_out.kind == FLIT_DATA) begin
                check_data_flit();
            end else if (link_out.valid) begin
                check_train_flit();
            end
        end
    end

    // Remote receiver frees one buffer per cycle when allowed
    always @(posedge clk) begin
        #0.5;
        if (owed > 0 && (returns_on || release_budget > 0)) begin
            link_credit_return = 1'b1;
            owed--;
            if (!returns_on) begin
                release_budget--;
            end
        end else begin
            link_credit_return = 1'b0;
        end
    end

    // ======================================
    // Test sequence
    // ======================================

    initial begin
        int base_err;
        int target;
        int gap;
        int train_base;
        clk                = 1'b0;
        async_rst_n        = 1'b0;
        link_enable        = 1'b0;
        remote_train_ack   = 1'b0;
        link_credit_return = 1'b0;
        for (int p = 0; p < NUM_PROTOCOLS; p++) begin
            proto_in[p]      = '0;
            exp_head[p]      = 0;
            exp_tail[p]      = 0;
            pushed[p]        = 0;
            credit_pulses[p] = 0;
            link_count[p]    = 0;
        end
        max_outstanding = 0;
        data_count      = 0;
        train_count     = 0;
        owed            = 0;
        release_budget  = 0;
        returns_on      = 1'b1;
        rr_check        = 1'b0;
        rr_next         = 0;
        next_seq        = '0;
        checks          = 0;
        errors          = 0;
        seed            = 97104;
        load_file();
        wait_cycles(3);
        async_rst_n = 1'b1;

        // Test 1, link training
        base_err = errors;
        compare_count(int'(link_out.valid), 0, "link_out valid after reset");
        compare_count(int'(proto_credit_return), 0, "credit returns after reset");
        compare_state(link_up, 1'b0, FLIT_TRAIN, FLIT_TRAIN, "link_up after reset");
        link_enable = 1'b1;
        wait_train_flits(6);
        compare_state(link_up, 1'b0, link_out.kind, FLIT_TRAIN, "link held down without ack");
        remote_train_ack = 1'b1;
        wait_link(1'b1);
        train_base = train_count;
        wait_cycles(6);
        compare_count(train_count - train_base, 0, "training flits after link_up");
        report_test(1, "training", base_err);

        // Test 2, payload integrity and per-protocol order
        base_err = errors;
        target   = data_count + n_entries;
        for (int i = 0; i < n_entries; i++) begin
            gap = $unsigned($random(seed)) % 4;
            wait_cycles(gap);
            push_entry(i);
        end
        wait_data(target, "test 2 DATA flits");
        report_test(2, "integrity and ordering", base_err);

        // Test 3, queues loaded during retraining
        base_err = errors;
        settle_credits();
        link_enable      = 1'b0;
        remote_train_ack = 1'b0;
        wait_link(1'b0);
        link_enable = 1'b1;
        rr_check    = 1'b1;
        rr_next     = 0;
        target      = data_count + n_entries;
        for (int i = 0; i < n_entries; i++) begin
            push_entry(i);
        end
        remote_train_ack = 1'b1;
        wait_link(1'b1);
        wait_data(target, "test 3 DATA flits");
        rr_check = 1'b0;
        report_test(3, "round robin", base_err);

        // Test 4, remote buffers exhausted then released three at a time
        base_err = errors;
        settle_credits();
        returns_on = 1'b0;
        target     = data_count;
        for (int i = 0; i < 12; i++) begin
            push_entry(i);
        end
        wait_data(target + LINK_CREDITS, "first link credit window");
        wait_cycles(12);
        compare_count(data_count - target, LINK_CREDITS, "DATA flits with returns paused");
        release_budget = 3;
        wait_data(target + LINK_CREDITS + 3, "flits after three returns");
        wait_cycles(12);
        compare_count(data_count - target, LINK_CREDITS + 3, "DATA flits after three returns");
        returns_on = 1'b1;
        wait_data(target + 12, "test 4 drain");
        report_test(4, "link credits", base_err);

        // Test 5, protocol credit accounting
        base_err = errors;
        settle_credits();
        for (int p = 0; p < NUM_PROTOCOLS; p++) begin
            compare_count(credit_pulses[p], link_count[p], "credit pulses vs link flits");
        end
        compare_count(max_outstanding, QUEUE_DEPTH, "peak outstanding flits per source");
        report_test(5, "protocol credits", base_err);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/link_input.txt ====
# proto_id payload_hex expected_crc_hex
# CRC-8 poly 07, init 0, over proto_id then payload
0 00000001 07
1 00000010 12
2 00000100 D1
3 00001000 F1
0 00010000 6B
1 00100000 C0
2 01000000 D2
3 10000000 C1
0 80000001 36
1 00008002 DA
2 00400020 A2
3 20000004 74
0 0000FF00 D7
1 40000008 C1
2 00000080 4D
3 00000000 A6

// ==== src.f ====
src/ucie_pkg.sv
src/proto_ingress_queue.sv
src/proto_arbiter.sv
src/flit_framer.sv
src/link_tx_port.sv
src/d2d_link_controller.sv
tests/d2d_link_controller_tb.sv
